//--- compile.f
uart_pkg.sv
uart_baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_loopback_top.sv
tb_uart_loopback.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the loopback UART testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_uart_loopback -f compile.f -o sim_uart \
	&& ./obj_dir/sim_uart > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log

grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- tb_uart_loopback.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_loopback import uart_pkg::*; ();

	localparam int DW         = DEF_DATA_WIDTH;
	localparam int BIT_CLKS   = DEF_CLK_DIV * DEF_OVERSAMPLE; // clocks per bit period
	localparam int FRAME_BITS = DW + DEF_PARITY_EN + 2;
	localparam int FRAME_CLKS = FRAME_BITS * BIT_CLKS;
	// worst start edge to valid latency plus margin
	localparam int RX_BOUND   = SYNC_STAGES + 1 + FRAME_CLKS + 2 * BIT_CLKS;

	logic          clk;
	logic          reset;
	logic          enable;
	logic [DW-1:0] data;
	logic          serial_in;
	logic          loopback;
	logic          busy;
	logic          serial_out;
	logic [DW-1:0] received_data;
	logic          data_valid;
	logic          rx_error;

	logic [DW:0]   sent_q[$];   // {expected error, byte} in send order
	logic [DW:0]   exp_head;    // queue front held steady through the valid cycle
	logic          exp_pending; // something still outstanding
	logic          valid_q;     // delayed valid that pops the queue
	logic          idle_chk;    // line must sit idle while set
	logic [31:0]   seed;
	int            chk_err;     // bumped by assertion failures
	int            wait_err;    // bumped by timeouts
	int            pass_cnt;
	int            fail_cnt;

	uart_loopback_top #(
		.DATA_WIDTH(DW), .PARITY_EN(DEF_PARITY_EN), .PARITY_ODD(DEF_PARITY_ODD),
		.CLK_DIV(DEF_CLK_DIV), .OVERSAMPLE(DEF_OVERSAMPLE)
	) dut (
		.clk(clk), .reset(reset), .i_enable(enable), .i_data(data),
		.i_serial_in(serial_in), .i_loopback(loopback), .o_busy(busy),
		.o_serial_out(serial_out), .o_received_data(received_data),
		.o_data_valid(data_valid), .o_rx_error(rx_error)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// reference model that pops one cycle after valid so exp_head holds for the check
	always @(posedge clk) begin
		if (reset) begin
			valid_q     <= 1'b0;
			exp_pending <= 1'b0;
			exp_head    <= '0;
		end else begin
			valid_q <= data_valid;
			if (valid_q && sent_q.size() > 0) begin
				void'(sent_q.pop_front());
			end
			exp_pending <= (sent_q.size() > 0);
			exp_head    <= (sent_q.size() > 0) ? sent_q[0] : '0;
		end
	end

	a_rx_data: assert property (@(posedge clk) disable iff (reset)
		data_valid && exp_pending |-> received_data == exp_head[DW-1:0])
		else begin
			$display("CHECK FAILED t=%0t o_received_data got %h expected %h",
				$time, received_data, exp_head[DW-1:0]);
			chk_err++;
		end

	a_rx_err: assert property (@(posedge clk) disable iff (reset)
		data_valid && exp_pending |-> rx_error == exp_head[DW])
		else begin
			$display("CHECK FAILED t=%0t o_rx_error got %b expected %b",
				$time, rx_error, exp_head[DW]);
			chk_err++;
		end

	a_no_extra: assert property (@(posedge clk) disable iff (reset)
		data_valid |-> exp_pending)
		else begin
			$display("t=%0t receiver gave a valid pulse with no byte outstanding", $time);
			chk_err++;
		end

	a_busy_rise: assert property (@(posedge clk) disable iff (reset)
		enable && !busy |=> busy)
		else begin
			$display("CHECK FAILED t=%0t o_busy got %b expected 1", $time, busy);
			chk_err++;
		end

	a_idle_line: assert property (@(posedge clk) disable iff (reset)
		idle_chk |-> serial_out)
		else begin
			$display("CHECK FAILED t=%0t o_serial_out got %b expected 1", $time, serial_out);
			chk_err++;
		end

	a_idle_busy: assert property (@(posedge clk) disable iff (reset)
		idle_chk |-> !busy)
		else begin
			$display("CHECK FAILED t=%0t o_busy got %b expected 0", $time, busy);
			chk_err++;
		end

	a_idle_valid: assert property (@(posedge clk) disable iff (reset)
		idle_chk |-> !data_valid && !rx_error)
		else begin
			$display("CHECK FAILED t=%0t o_data_valid/o_rx_error got %b/%b expected 0/0",
				$time, data_valid, rx_error);
			chk_err++;
		end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// parity bit that makes the count of ones even, or odd for odd parity
	function automatic logic parity_of(input logic [DW-1:0] b);
		int ones;
		ones = 0;
		for (int k = 0; k < DW; k++) begin
			if (b[k]) begin
				ones++;
			end
		end
		return (ones % 2 == 1) != (DEF_PARITY_ODD != 0);
	endfunction

	function automatic int total_errors();
		return chk_err + wait_err;
	endfunction

	task automatic send_byte(input logic [DW-1:0] b);
		sent_q.push_back({1'b0, b});
		enable <= 1'b1;
		data   <= b;
		@(posedge clk);
		enable <= 1'b0; // one clock strobe
	endtask

	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (busy !== level && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (busy !== level) begin
			$display("t=%0t timed out after %0d cycles waiting for %s", $time, limit, what);
			wait_err++;
		end
	endtask

	task automatic wait_drained(input int limit);
		int n;
		n = 0;
		while (exp_pending && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (exp_pending) begin
			$display("t=%0t timed out, %0d bytes never came back", $time, sent_q.size());
			wait_err++;
		end
	endtask

	task automatic quiet_window(input int cycles);
		idle_chk <= 1'b1;
		repeat (cycles) @(posedge clk);
		idle_chk <= 1'b0;
	endtask

	// bit-bang one frame on the external pin, then idle two bit periods
	task automatic drive_pin_frame(input logic [DW-1:0] b, input logic par, input logic stop,
		input logic err);
		logic [FRAME_BITS-1:0] f;
		f = '1;
		f[0] = 1'b0;
		f[DW:1] = b;
		if (DEF_PARITY_EN != 0) begin
			f[DW+1] = par;
		end
		f[FRAME_BITS-1] = stop;
		sent_q.push_back({err, b});
		for (int k = 0; k < FRAME_BITS; k++) begin
			serial_in <= f[k];
			repeat (BIT_CLKS) @(posedge clk);
		end
		serial_in <= 1'b1;
		repeat (2 * BIT_CLKS) @(posedge clk);
	endtask

	task automatic end_test(input int num, input string name, input int errs_before);
		if (total_errors() == errs_before) begin
			pass_cnt++;
			$display("test %0d %s: ok", num, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: failed with %0d errors", num, name,
				total_errors() - errs_before);
		end
	endtask

	initial begin
		int errs;
		logic [DW-1:0] b;
		reset     = 1'b1;
		enable    = 1'b0;
		data      = '0;
		serial_in = 1'b1; // pin idles high
		loopback  = 1'b1;
		idle_chk  = 1'b0;
		seed      = 32'h4bd85356;
		chk_err   = 0;
		wait_err  = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		errs = total_errors();
		quiet_window(4 * BIT_CLKS);
		end_test(1, "idle after reset", errs);

		errs = total_errors();
		send_byte(8'h5a);
		wait_busy(1'b1, 4, "busy to rise");
		wait_busy(1'b0, FRAME_CLKS + 2 * BIT_CLKS, "busy to fall");
		wait_drained(RX_BOUND);
		quiet_window(2 * BIT_CLKS); // no second pulse
		end_test(2, "single loopback byte", errs);

		errs = total_errors();
		for (int i = 0; i < 20; i++) begin
			seed = lcg_next(seed);
			b    = seed[31:32-DW]; // upper bits of the lcg are the better ones
			send_byte(b);
			wait_busy(1'b1, 4, "busy to rise");
			wait_busy(1'b0, FRAME_CLKS + 2 * BIT_CLKS, "busy to fall");
		end
		wait_drained(RX_BOUND);
		end_test(3, "random back-to-back stream", errs);

		errs = total_errors();
		send_byte(8'hc3);
		wait_busy(1'b1, 4, "busy to rise");
		enable <= 1'b1; // strobe during busy that the tx must drop
		data   <= 8'h3c;
		@(posedge clk);
		enable <= 1'b0;
		wait_busy(1'b0, FRAME_CLKS + 2 * BIT_CLKS, "busy to fall");
		wait_drained(RX_BOUND);
		quiet_window(FRAME_CLKS + 2 * BIT_CLKS);
		end_test(4, "enable while busy ignored", errs);

		errs = total_errors();
		loopback <= 1'b0;
		@(posedge clk);
		drive_pin_frame(8'ha5, ~parity_of(8'ha5), 1'b1, DEF_PARITY_EN != 0);
		drive_pin_frame(8'h3c, parity_of(8'h3c), 1'b0, 1'b1); // framing error
		seed = lcg_next(seed);
		b    = seed[31:32-DW];
		drive_pin_frame(b, parity_of(b), 1'b1, 1'b0);
		wait_drained(RX_BOUND);
		end_test(5, "error detection on external pin", errs);

		$display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && total_errors() == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- uart_baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen #(
	parameter int CLK_DIV    = 2,
	parameter int OVERSAMPLE = 8
) (
	input  wire  clk,
	input  wire  reset,
	output logic o_os_tick,  // one clock wide, every CLK_DIV clocks
	output logic o_bit_tick  // one clock wide, with every OVERSAMPLE-th os tick
);

	localparam int PRE_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int OS_W  = (OVERSAMPLE > 1) ? $clog2(OVERSAMPLE) : 1;

	logic [PRE_W-1:0] pre_cnt; // clock prescaler
	logic [OS_W-1:0]  os_cnt;  // os ticks within the current bit

	always_ff @(posedge clk) begin
		if (reset) begin
			pre_cnt    <= '0;
			os_cnt     <= '0;
			o_os_tick  <= 1'b0;
			o_bit_tick <= 1'b0;
		end else begin
			o_os_tick  <= 1'b0; // strobes by default
			o_bit_tick <= 1'b0;
			if (pre_cnt == PRE_W'(CLK_DIV - 1)) begin
				pre_cnt   <= '0;
				o_os_tick <= 1'b1;
				if (os_cnt == OS_W'(OVERSAMPLE - 1)) begin
					os_cnt     <= '0;
					o_bit_tick <= 1'b1; // bit boundary lands on an os tick
				end else begin
					os_cnt <= os_cnt + 1'b1;
				end
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

	// tx and rx stay phase-related only if every bit tick is also an os tick
	a_bit_on_os: assert property (@(posedge clk) disable iff (reset)
		o_bit_tick |-> o_os_tick);

endmodule

`default_nettype wire

//--- uart_loopback_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_loopback_top import uart_pkg::*; #(
	parameter int DATA_WIDTH = DEF_DATA_WIDTH,
	parameter int PARITY_EN  = DEF_PARITY_EN,
	parameter int PARITY_ODD = DEF_PARITY_ODD,
	parameter int CLK_DIV    = DEF_CLK_DIV,
	parameter int OVERSAMPLE = DEF_OVERSAMPLE
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   i_enable,        // transmit request strobe
	input  wire  [DATA_WIDTH-1:0] i_data,
	input  wire                   i_serial_in,     // external rx pin
	input  wire                   i_loopback,      // 1 = rx listens to our own tx
	output logic                  o_busy,
	output logic                  o_serial_out,
	output logic [DATA_WIDTH-1:0] o_received_data,
	output logic                  o_data_valid,
	output logic                  o_rx_error
);

	logic os_tick;  // rx timebase
	logic bit_tick; // tx timebase
	logic rx_line;

	assign rx_line = i_loopback ? o_serial_out : i_serial_in; // plain mux without a flop

	uart_baud_gen #(.CLK_DIV(CLK_DIV), .OVERSAMPLE(OVERSAMPLE)) u_baud (
		.clk(clk), .reset(reset), .o_os_tick(os_tick), .o_bit_tick(bit_tick)
	);

	uart_tx #(.DATA_WIDTH(DATA_WIDTH), .PARITY_EN(PARITY_EN), .PARITY_ODD(PARITY_ODD)) u_tx (
		.clk(clk), .reset(reset), .i_bit_tick(bit_tick), .i_enable(i_enable),
		.i_data(i_data), .o_busy(o_busy), .o_serial_out(o_serial_out)
	);

	uart_rx #(
		.DATA_WIDTH(DATA_WIDTH), .PARITY_EN(PARITY_EN),
		.PARITY_ODD(PARITY_ODD), .OVERSAMPLE(OVERSAMPLE)
	) u_rx (
		.clk(clk), .reset(reset), .i_os_tick(os_tick), .i_serial_in(rx_line),
		.o_received_data(o_received_data), .o_data_valid(o_data_valid),
		.o_rx_error(o_rx_error)
	);

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

	// transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE = 2'd0, // line high, waiting for an enable strobe
		TX_LOAD = 2'd1, // frame loaded, waiting for the next bit tick
		TX_SEND = 2'd2  // shifting the frame out, one bit per tick
	} tx_state_t;

	// receiver FSM
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0, // watching for a high to low edge
		RX_START  = 3'd1, // half a bit into the start bit
		RX_DATA   = 3'd2, // sampling data bits at mid-bit
		RX_PARITY = 3'd3, // sampling the parity bit
		RX_STOP   = 3'd4  // sampling the stop bit, then publish
	} rx_state_t;

	// flops between the serial pin and the receiver FSM
	localparam int SYNC_STAGES = 3;

	// frame defaults, handed down by the top level
	localparam int DEF_DATA_WIDTH = 8; // data bits per frame
	localparam int DEF_PARITY_EN  = 1; // 1 = parity bit present
	localparam int DEF_PARITY_ODD = 0; // 0 = even parity, 1 = odd

	// baud defaults; one bit period is CLK_DIV * OVERSAMPLE clocks
	localparam int DEF_CLK_DIV    = 2; // clocks per oversample tick
	localparam int DEF_OVERSAMPLE = 8; // oversample ticks per bit

endpackage

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; #(
	parameter int DATA_WIDTH = 8,
	parameter int PARITY_EN  = 1,
	parameter int PARITY_ODD = 0,
	parameter int OVERSAMPLE = 8
) (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   i_os_tick,       // oversample strobe
	input  wire                   i_serial_in,     // asynchronous line
	output logic [DATA_WIDTH-1:0] o_received_data, // held until the next valid
	output logic                  o_data_valid,    // one-clock pulse
	output logic                  o_rx_error       // parity or framing, with valid
);

	localparam int OS_W  = (OVERSAMPLE > 1) ? $clog2(OVERSAMPLE) : 1;
	localparam int IDX_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
	localparam int HALF  = (OVERSAMPLE > 1) ? OVERSAMPLE / 2 : 1;

	rx_state_t              state;
	logic [SYNC_STAGES-1:0] sync_q;    // metastability chain
	logic                   line;      // synchronized line
	logic                   line_q;    // one clock older for edge detect
	logic [OS_W-1:0]        os_cnt;    // os ticks since last sample point
	logic [OS_W-1:0]        os_last;   // wrap value for the current state
	logic                   mid;       // sample point of the current bit
	logic [IDX_W-1:0]       bit_idx;   // data bit being sampled
	logic [DATA_WIDTH-1:0]  data_q;    // shifted in with the LSB first
	logic                   par_q;     // sampled parity bit
	logic                   par_err;
	logic                   fall;

	assign line = sync_q[SYNC_STAGES-1];
	assign fall = line_q & ~line;

	// half a bit to reach the start bit middle, then whole bits
	assign os_last = (state == RX_START) ? OS_W'(HALF - 1) : OS_W'(OVERSAMPLE - 1);
	assign mid     = i_os_tick && (os_cnt == os_last);

	assign par_err = (PARITY_EN != 0) && (par_q != ((^data_q) ^ (PARITY_ODD != 0)));

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q          <= '1; // pin assumed idle
			line_q          <= 1'b1;
			state           <= RX_IDLE;
			os_cnt          <= '0;
			bit_idx         <= '0;
			o_received_data <= '0;
			o_data_valid    <= 1'b0;
			o_rx_error      <= 1'b0;
		end else begin
			sync_q       <= {sync_q[SYNC_STAGES-2:0], i_serial_in};
			line_q       <= line;
			o_data_valid <= 1'b0; // pulses
			o_rx_error   <= 1'b0;

			if (state == RX_IDLE || mid) begin
				os_cnt <= '0; // parked in idle and restarted at each sample point
			end else if (i_os_tick) begin
				os_cnt <= os_cnt + 1'b1;
			end

			case (state)
				RX_IDLE: begin
					if (fall) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (mid) begin
						bit_idx <= '0;
						// still high at the middle means a glitch
						state   <= line ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (mid) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_W'(DATA_WIDTH - 1)) begin
							state <= (PARITY_EN != 0) ? RX_PARITY : RX_STOP;
						end
					end
				end
				RX_PARITY: begin
					if (mid) begin
						state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (mid) begin
						o_received_data <= data_q;
						o_data_valid    <= 1'b1;
						o_rx_error      <= par_err | ~line; // low stop is a framing error
						state           <= RX_IDLE;          // half a bit left to find next start
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// payload capture
	always_ff @(posedge clk) begin
		if (state == RX_DATA && mid) begin
			data_q <= {line, data_q[DATA_WIDTH-1:1]};
		end
		if (state == RX_PARITY && mid) begin
			par_q <= line;
		end
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		o_data_valid |=> !o_data_valid);

	a_err_with_valid: assert property (@(posedge clk) disable iff (reset)
		o_rx_error |-> o_data_valid);

	// still resting in idle after publishing, ready for the next start edge
	a_idle_after_valid: assert property (@(posedge clk) disable iff (reset)
		o_data_valid |=> state == RX_IDLE);

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; #(
	parameter int DATA_WIDTH = 8,
	parameter int PARITY_EN  = 1,
	parameter int PARITY_ODD = 0
) (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  i_bit_tick,   // bit period strobe from the baud generator
	input  wire                  i_enable,     // one-clock request strobe
	input  wire [DATA_WIDTH-1:0] i_data,       // sampled on the accepting edge
	output logic                 o_busy,
	output logic                 o_serial_out  // idles high
);

	// start + data + optional parity + stop
	localparam int FRAME_BITS = DATA_WIDTH + PARITY_EN + 2;
	localparam int CNT_W      = $clog2(FRAME_BITS + 1);

	tx_state_t              state;
	logic [FRAME_BITS-1:0]  shift_reg; // frame with the LSB going out first
	logic [FRAME_BITS-1:0]  frame;     // frame assembled from i_data
	logic [CNT_W-1:0]       bit_cnt;   // bits already driven onto the line
	logic                   parity;

	// even parity is the xor of the data, odd flips it
	assign parity = (^i_data) ^ (PARITY_ODD != 0);

	always_comb begin
		frame                = '1;     // stop bit and any unused slot stay high
		frame[0]             = 1'b0;   // start bit
		frame[DATA_WIDTH:1]  = i_data;
		if (PARITY_EN != 0) begin
			frame[DATA_WIDTH+1] = parity; // sits just below the stop bit
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= TX_IDLE;
			bit_cnt      <= '0;
			o_busy       <= 1'b0;
			o_serial_out <= 1'b1; // line idles high
		end else begin
			case (state)
				TX_IDLE: begin
					if (i_enable) begin // busy is low in idle so the strobe is taken
						state  <= TX_LOAD;
						o_busy <= 1'b1;
					end
				end
				TX_LOAD: begin
					if (i_bit_tick) begin
						o_serial_out <= shift_reg[0]; // start bit
						bit_cnt      <= CNT_W'(1);
						state        <= TX_SEND;
					end
				end
				TX_SEND: begin
					if (i_bit_tick) begin
						if (bit_cnt == CNT_W'(FRAME_BITS)) begin
							// stop bit has had its full period
							o_busy <= 1'b0;
							state  <= TX_IDLE;
						end else begin
							o_serial_out <= shift_reg[0];
							bit_cnt      <= bit_cnt + 1'b1;
						end
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// frame shift register
	always_ff @(posedge clk) begin
		if (state == TX_IDLE && i_enable) begin
			shift_reg <= frame;
		end else if (i_bit_tick && state != TX_IDLE) begin
			shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]}; // back-fill with idle level
		end
	end

	// rx start detection depends on a high line between frames
	a_idle_high: assert property (@(posedge clk) disable iff (reset)
		state == TX_IDLE |-> o_serial_out);

	// busy must cover the whole frame or a new request would corrupt it
	a_busy_cover: assert property (@(posedge clk) disable iff (reset)
		state != TX_IDLE |-> o_busy);

endmodule

`default_nettype wire
